/* Bender.yml */
package:
  name: mipsPipeline

export_include_dirs:
  - include

sources:
  - files:
      - logic/mipsPkg.sv
      - logic/controlDecoder.sv
      - logic/registerFile.sv
      - logic/executeUnit.sv
      - logic/dataMemory.sv
      - logic/mipsPipeline.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/clockGen.sv
      - tests/mipsPipelineAsserts.sv
      - tests/mipsPipelineTb.sv

/* all.f */
+incdir+include
logic/mipsPkg.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/dataMemory.sv
logic/mipsPipeline.sv
tests/clockGen.sv
tests/mipsPipelineAsserts.sv
tests/mipsPipelineTb.sv

/* include/mipsConsts.svh */
/*
 * Widths, data memory depth and instruction encodings for the MIPS core.
 * Included by the package and by every module that decodes or sizes things.
 */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define DMEM_DEPTH  256

// primary opcodes, instr[31:26]
`define OP_RTYPE    6'h00
`define OP_ADDI     6'h08
`define OP_LW       6'h23
`define OP_SW       6'h2b
`define OP_BEQ      6'h04

// R-type function codes, instr[5:0]
`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

// internal ALU operation codes
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_SLT     3'd4

// operand forwarding choices
`define FWD_REG     2'd0
`define FWD_EXMEM   2'd1
`define FWD_MEMWB   2'd2

`endif

/* logic/controlDecoder.sv */
/*
 * Main control for the decode stage. Turns opcode and function field into
 * the control word; anything not recognised becomes a nop.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mipsConsts.svh"

module controlDecoder (
    input  mipsPkg::word     instr,
    output mipsPkg::ctrlWord ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            `OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (funct)
                    `FN_ADD: ctrl.aluSel = `ALU_ADD;
                    `FN_SUB: ctrl.aluSel = `ALU_SUB;
                    `FN_AND: ctrl.aluSel = `ALU_AND;
                    `FN_OR:  ctrl.aluSel = `ALU_OR;
                    `FN_SLT: ctrl.aluSel = `ALU_SLT;
                    // unknown funct, includes the all-zero word
                    default: ctrl = '0;
                endcase
            end
            `OP_ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSel    = `ALU_ADD;
            end
            `OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSel    = `ALU_ADD;
            end
            `OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSel    = `ALU_ADD;
            end
            `OP_BEQ: begin
                // compare by subtraction, zero flag decides
                ctrl.branch = 1'b1;
                ctrl.aluSel = `ALU_SUB;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/dataMemory.sv */
/*
 * Word-addressed data memory for the MEM stage. Combinational read,
 * write on the clock edge, whole array cleared by reset.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mipsConsts.svh"

module dataMemory (
    input  logic         clk,
    input  logic         reset,
    input  logic         rd,
    input  logic         wr,
    input  mipsPkg::word addr,
    input  mipsPkg::word wrData,
    output mipsPkg::word rdData
);
    import mipsPkg::*;

    localparam int idxW = $clog2(`DMEM_DEPTH);

    word             mem [`DMEM_DEPTH];
    logic [idxW-1:0] idx;

    // drop the byte offset, upper bits wrap
    assign idx = addr[2 +: idxW];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr) begin
            mem[idx] <= wrData;
        end
    end

    assign rdData = rd ? mem[idx] : '0;

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
/*
 * Execute stage datapath. Forwards from EX/MEM and MEM/WB into the ALU
 * operands, applies the immediate, runs the ALU and picks the destination.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mipsConsts.svh"

module executeUnit (
    input  mipsPkg::idExReg idEx,
    input  mipsPkg::word    exMemResult,
    input  mipsPkg::regAddr exMemDest,
    input  logic            exMemRegWrite,
    input  mipsPkg::word    wbData,
    input  mipsPkg::regAddr wbDest,
    input  logic            wbRegWrite,
    output mipsPkg::word    result,
    output logic            zero,
    output mipsPkg::word    storeData,
    output mipsPkg::regAddr dest
);
    import mipsPkg::*;

    fwdSel fwdA;
    fwdSel fwdB;
    word   opA;
    word   rtVal;
    word   opB;

    // youngest producer wins, r0 is never forwarded
    function automatic fwdSel pickFwd(regAddr src);
        if (src == '0) return `FWD_REG;
        if (exMemRegWrite && exMemDest == src) return `FWD_EXMEM;
        if (wbRegWrite && wbDest == src) return `FWD_MEMWB;
        return `FWD_REG;
    endfunction

    function automatic word fwdValue(fwdSel sel, word regVal);
        case (sel)
            `FWD_EXMEM: return exMemResult;
            `FWD_MEMWB: return wbData;
            default:    return regVal;
        endcase
    endfunction

    always_comb begin
        fwdA  = pickFwd(idEx.rs);
        fwdB  = pickFwd(idEx.rt);
        opA   = fwdValue(fwdA, idEx.rsData);
        rtVal = fwdValue(fwdB, idEx.rtData);
        opB   = idEx.ctrl.aluSrcImm ? idEx.imm : rtVal;
    end

    always_comb begin
        case (idEx.ctrl.aluSel)
            `ALU_ADD: result = opA + opB;
            `ALU_SUB: result = opA - opB;
            `ALU_AND: result = opA & opB;
            `ALU_OR:  result = opA | opB;
            `ALU_SLT: result = {{(`XLEN - 1){1'b0}}, $signed(opA) < $signed(opB)};
            default:  result = '0;
        endcase
    end

    assign zero      = (result == '0);
    assign storeData = rtVal;
    assign dest      = idEx.ctrl.regDstRd ? idEx.rd : idEx.rt;

endmodule

`default_nettype wire

/* logic/mipsPipeline.sv */
/*
 * Top of the five-stage MIPS core. Holds the PC and pipeline registers,
 * resolves beq in MEM and drives the writeback strobe. Instructions come
 * from outside through fetchAddr and instr.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mipsConsts.svh"

module mipsPipeline (
    input  logic           clk,
    input  logic           reset,
    input  mipsPkg::word   instr,
    output mipsPkg::word   fetchAddr,
    output mipsPkg::wbPort wb
);
    import mipsPkg::*;

    word     pc;
    word     pcPlus4;
    logic    ifIdValid;
    word     ifIdInstr;
    word     ifIdPcNext;
    idExReg  idEx;
    exMemReg exMem;
    memWbReg memWb;

    ctrlWord decCtrl;
    word     rsData;
    word     rtData;
    word     immExt;
    word     exResult;
    logic    exZero;
    word     exStoreData;
    regAddr  exDest;
    word     exBranchTarget;
    word     loadWord;
    word     wbData;
    logic    wbWrite;
    logic    branchTaken;

    // fetch
    assign fetchAddr = pc;
    assign pcPlus4   = pc + 32'd4;

    // beq resolves in MEM, squashing the three younger instructions
    assign branchTaken = exMem.valid && exMem.ctrl.branch && exMem.zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= exMem.branchTarget;
        end else begin
            pc <= pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ifIdValid <= 1'b0;
        end else begin
            ifIdValid  <= !branchTaken;
            ifIdInstr  <= instr;
            ifIdPcNext <= pcPlus4;
        end
    end

    // decode
    assign immExt = {{(`XLEN - 16){ifIdInstr[15]}}, ifIdInstr[15:0]};

    controlDecoder decoder (
        .instr (ifIdInstr),
        .ctrl  (decCtrl)
    );

    registerFile regFile (
        .clk     (clk),
        .reset   (reset),
        .rdAddrA (ifIdInstr[25:21]),
        .rdAddrB (ifIdInstr[20:16]),
        .wrEn    (wbWrite),
        .wrAddr  (memWb.dest),
        .wrData  (wbData),
        .rdDataA (rsData),
        .rdDataB (rtData)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid  <= ifIdValid && !branchTaken;
            idEx.ctrl   <= decCtrl;
            idEx.pcNext <= ifIdPcNext;
            idEx.rsData <= rsData;
            idEx.rtData <= rtData;
            idEx.imm    <= immExt;
            idEx.rs     <= ifIdInstr[25:21];
            idEx.rt     <= ifIdInstr[20:16];
            idEx.rd     <= ifIdInstr[15:11];
        end
    end

    // execute
    executeUnit execute (
        .idEx          (idEx),
        .exMemResult   (exMem.result),
        .exMemDest     (exMem.dest),
        .exMemRegWrite (exMem.valid && exMem.ctrl.regWrite),
        .wbData        (wbData),
        .wbDest        (memWb.dest),
        .wbRegWrite    (wbWrite),
        .result        (exResult),
        .zero          (exZero),
        .storeData     (exStoreData),
        .dest          (exDest)
    );

    // word offset relative to the instruction after the beq
    assign exBranchTarget = idEx.pcNext + {idEx.imm[`XLEN-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid        <= idEx.valid && !branchTaken;
            exMem.ctrl         <= idEx.ctrl;
            exMem.result       <= exResult;
            exMem.zero         <= exZero;
            exMem.storeData    <= exStoreData;
            exMem.dest         <= exDest;
            exMem.branchTarget <= exBranchTarget;
        end
    end

    // memory
    dataMemory dmem (
        .clk    (clk),
        .reset  (reset),
        .rd     (exMem.ctrl.memRead),
        .wr     (exMem.valid && exMem.ctrl.memWrite),
        .addr   (exMem.result),
        .wrData (exMem.storeData),
        .rdData (loadWord)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            memWb.valid <= 1'b0;
        end else begin
            memWb.valid    <= exMem.valid;
            memWb.regWrite <= exMem.ctrl.regWrite;
            memWb.memRead  <= exMem.ctrl.memRead;
            memWb.result   <= exMem.result;
            memWb.loadData <= loadWord;
            memWb.dest     <= exMem.dest;
        end
    end

    // writeback
    assign wbWrite = memWb.valid && memWb.regWrite;
    assign wbData  = memWb.memRead ? memWb.loadData : memWb.result;

    // strobe only for a real register update
    assign wb.valid = wbWrite && (memWb.dest != '0);
    assign wb.dest  = memWb.dest;
    assign wb.data  = wbData;

endmodule

`default_nettype wire

/* logic/mipsPkg.sv */
/*
 * Shared types of the MIPS core: value typedefs, the control word and the
 * pipeline register layouts. Modules import it inside their bodies.
 */
`default_nettype none

`include "mipsConsts.svh"

package mipsPkg;

    typedef logic [`XLEN-1:0]       word;
    typedef logic [`REG_ADDR_W-1:0] regAddr;
    typedef logic [2:0]             aluOp;
    typedef logic [1:0]             fwdSel;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic branch;
        logic aluSrcImm;
        logic regDstRd;
        aluOp aluSel;
    } ctrlWord;

    // decode to execute
    typedef struct packed {
        logic    valid;
        ctrlWord ctrl;
        word     pcNext;
        word     rsData;
        word     rtData;
        word     imm;
        regAddr  rs;
        regAddr  rt;
        regAddr  rd;
    } idExReg;

    // execute to memory
    typedef struct packed {
        logic    valid;
        ctrlWord ctrl;
        word     result;
        logic    zero;
        word     storeData;
        regAddr  dest;
        word     branchTarget;
    } exMemReg;

    // memory to writeback
    typedef struct packed {
        logic   valid;
        logic   regWrite;
        logic   memRead;
        word    result;
        word    loadData;
        regAddr dest;
    } memWbReg;

    typedef struct packed {
        logic   valid;
        regAddr dest;
        word    data;
    } wbPort;

endpackage

`default_nettype wire

/* logic/registerFile.sv */
/*
 * 32 x 32 register file, two read ports and one write port.
 * Register 0 reads zero; a same-cycle write is visible on the read ports.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mipsConsts.svh"

module registerFile (
    input  logic            clk,
    input  logic            reset,
    input  mipsPkg::regAddr rdAddrA,
    input  mipsPkg::regAddr rdAddrB,
    input  logic            wrEn,
    input  mipsPkg::regAddr wrAddr,
    input  mipsPkg::word    wrData,
    output mipsPkg::word    rdDataA,
    output mipsPkg::word    rdDataB
);
    import mipsPkg::*;

    // register 0 has no storage
    word regs [1:(1 << `REG_ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    function automatic word readPort(regAddr a);
        if (a == '0) return '0;
        // write-through, decode sees the value retiring this cycle
        if (wrEn && a == wrAddr) return wrData;
        return regs[a];
    endfunction

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

endmodule

`default_nettype wire

/* tests/clockGen.sv */
/*
 * Clock and reset source for the testbench. 100 ns clock, reset held
 * high for the first 16 rising edges and released just after the last.
 */
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int halfPeriod   = 50,
    parameter int resetCycles  = 16,
    parameter int releaseDelay = 1
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // release a little after the edge, like the other stimulus
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #releaseDelay;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tests/mipsPipelineAsserts.sv */
/*
 * Concurrent checks on the ports of the MIPS core, bound into every
 * mipsPipeline instance.
 */
`timescale 1ns/1ns
`default_nettype none

module mipsPipelineAsserts (
    input logic            clk,
    input logic            reset,
    input mipsPkg::word    fetchAddr,
    input mipsPkg::wbPort  wb
);
    import mipsPkg::*;

    // the edge after reset is seen, the strobe must be clear
    wbQuietInReset: assert property (@(posedge clk) reset |=> !wb.valid)
        else $error("wb.valid high while reset is asserted");

    wbDestNonZero: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> wb.dest != '0)
        else $error("writeback strobe with destination r0");

    fetchAligned: assert property (@(posedge clk) disable iff (reset)
        fetchAddr[1:0] == 2'b00)
        else $error("fetch address is not word aligned");

endmodule

bind mipsPipeline mipsPipelineAsserts portChecks (
    .clk       (clk),
    .reset     (reset),
    .fetchAddr (fetchAddr),
    .wb        (wb)
);

`default_nettype wire

/* tests/mipsPipelineTb.sv */
/*
 * Testbench for the MIPS core. Builds a random program, serves it on the
 * fetch port, runs it through a sequential ISA model and compares every
 * writeback strobe against the model's trace.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mipsConsts.svh"

module mipsPipelineTb;
    import mipsPkg::*;

    localparam int progLen      = 64;
    localparam int driveDelay   = 1;
    localparam int resetTimeout = 64;
    localparam int runTimeout   = 2000;
    localparam int drainCycles  = 20;

    logic  clk;
    logic  reset;
    word   instr;
    word   fetchAddr;
    wbPort wb;

    word         prog [progLen];
    word         modelRegs [32];
    word         modelMem [`DMEM_DEPTH];
    regAddr      expDest [$];
    word         expData [$];
    regAddr      wantDest;
    word         wantData;
    logic [31:0] rngState;
    int          expectedTotal;
    int          wbSeen;
    int          mismatchCount;
    int          failCount;

    clockGen clocks (
        .clk   (clk),
        .reset (reset)
    );

    mipsPipeline dut (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .fetchAddr (fetchAddr),
        .wb        (wb)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned randBelow(input int unsigned bound);
        rngState = xorshift(rngState);
        return rngState % bound;
    endfunction

    // pick from r0..r7 but not the register an lw just before is loading
    function automatic regAddr pickSource(input regAddr avoid);
        regAddr r;
        r = regAddr'(randBelow(8));
        if (avoid != '0 && r == avoid) r = '0;
        return r;
    endfunction

    function automatic logic [5:0] aluFunct(input int unsigned k);
        case (k)
            0:       return `FN_ADD;
            1:       return `FN_SUB;
            2:       return `FN_AND;
            3:       return `FN_OR;
            default: return `FN_SLT;
        endcase
    endfunction

    // word offsets 0..7 and now and then one memory span higher to wrap
    function automatic logic [15:0] memOffset();
        logic [15:0] off;
        off = 16'(randBelow(8) * 4);
        if (randBelow(4) == 0) off = off + 16'(`DMEM_DEPTH * 4);
        return off;
    endfunction

    task automatic buildProgram();
        int unsigned kind;
        regAddr      rs;
        regAddr      rt;
        regAddr      avoid;
        logic [15:0] imm;
        avoid = '0;
        for (int i = 0; i < progLen; i++) begin
            kind = randBelow(16);
            rs = pickSource(avoid);
            rt = pickSource(avoid);
            if (kind < 6) begin
                prog[i] = {`OP_RTYPE, rs, rt, 5'(randBelow(8)), 5'd0, aluFunct(randBelow(5))};
            end else if (kind < 9) begin
                imm = randBelow(2) ? 16'(randBelow(65536)) : 16'(int'(randBelow(64)) - 32);
                prog[i] = {`OP_ADDI, rs, 5'(randBelow(8)), imm};
            end else if (kind < 11) begin
                rt = regAddr'(randBelow(8));
                prog[i] = {`OP_LW, 5'd0, rt, memOffset()};
            end else if (kind < 13) begin
                prog[i] = {`OP_SW, 5'd0, rt, memOffset()};
            end else if (kind < 15) begin
                // half of them compare a register with itself
                if (randBelow(2) == 0) rt = rs;
                prog[i] = {`OP_BEQ, rs, rt, 16'(randBelow(4))};
            end else begin
                prog[i] = '0;
            end
            avoid = (prog[i][31:26] == `OP_LW) ? prog[i][20:16] : '0;
        end
    endtask

    task automatic recordWrite(input regAddr d, input word v);
        if (d != '0) begin
            modelRegs[d] = v;
            expDest.push_back(d);
            expData.push_back(v);
        end
    endtask

    // sequential ISA model where a taken branch goes straight to its target
    task automatic runModel();
        word pc;
        word ins;
        word a;
        word b;
        word imm;
        int  steps;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        for (int i = 0; i < `DMEM_DEPTH; i++) modelMem[i] = '0;
        pc = '0;
        steps = 0;
        while (pc < progLen * 4 && steps < 4 * progLen) begin
            ins = prog[pc >> 2];
            a = modelRegs[ins[25:21]];
            b = modelRegs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            pc = pc + 4;
            case (ins[31:26])
                `OP_RTYPE: begin
                    case (ins[5:0])
                        `FN_ADD: recordWrite(ins[15:11], a + b);
                        `FN_SUB: recordWrite(ins[15:11], a - b);
                        `FN_AND: recordWrite(ins[15:11], a & b);
                        `FN_OR:  recordWrite(ins[15:11], a | b);
                        `FN_SLT: recordWrite(ins[15:11], ($signed(a) < $signed(b)) ? 1 : 0);
                        default: ;
                    endcase
                end
                `OP_ADDI: recordWrite(ins[20:16], a + imm);
                `OP_LW:   recordWrite(ins[20:16], modelMem[((a + imm) >> 2) % `DMEM_DEPTH]);
                `OP_SW:   modelMem[((a + imm) >> 2) % `DMEM_DEPTH] = b;
                `OP_BEQ:  if (a == b) pc = pc + (imm << 2);
                default:  ;
            endcase
            steps++;
        end
    endtask

    function automatic word programWord(input word addr);
        if ($isunknown(addr) || addr >= progLen * 4) return '0;
        return prog[addr >> 2];
    endfunction

    // instruction memory answers the new PC shortly after each edge
    always @(posedge clk) begin
        #driveDelay;
        instr = programWord(fetchAddr);
    end

    task automatic checkWriteback();
        wbSeen++;
        if (expDest.size() == 0) begin
            failCount++;
            $display("unexpected writeback to r%0d at %0t, model has nothing left", wb.dest,
                     $time);
        end else begin
            wantDest = expDest.pop_front();
            wantData = expData.pop_front();
            if (wb.dest !== wantDest || wb.data !== wantData) begin
                mismatchCount++;
                $display("MISMATCH at %0t: writeback %0d is r%0d = %h, expected r%0d = %h",
                         $time, wbSeen, wb.dest, wb.data, wantDest, wantData);
            end
        end
    endtask

    // port rules and the writeback trace at the falling edge
    always @(negedge clk) begin
        if (reset === 1'b1) begin
            if (wb.valid !== 1'b0) begin
                mismatchCount++;
                $display("MISMATCH at %0t: wb.valid is %b during reset, expected 0",
                         $time, wb.valid);
            end
        end else begin
            if (fetchAddr[1:0] !== 2'b00) begin
                mismatchCount++;
                $display("MISMATCH at %0t: fetchAddr %h is not word aligned",
                         $time, fetchAddr);
            end
            if (wb.valid === 1'b1) begin
                checkWriteback();
            end else if (wb.valid !== 1'b0) begin
                failCount++;
                $display("wb.valid is unknown at %0t", $time);
            end
        end
    end

    task automatic finishRun();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d writebacks seen",
                 mismatchCount, failCount, wbSeen, expectedTotal);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin : mainFlow
        int waited;
        instr = '0;
        rngState = 32'haa8ac8a8;
        wbSeen = 0;
        mismatchCount = 0;
        failCount = 0;
        buildProgram();
        runModel();
        expectedTotal = expDest.size();

        waited = 0;
        while (reset !== 1'b0 && waited < resetTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0) begin
            failCount++;
            $display("reset was never released within %0d cycles", resetTimeout);
        end else if (fetchAddr !== '0) begin
            mismatchCount++;
            $display("MISMATCH at %0t: fetchAddr after reset is %h, expected 0", $time, fetchAddr);
        end

        waited = 0;
        while (wbSeen < expectedTotal && waited < runTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (wbSeen < expectedTotal) begin
            failCount++;
            $display("timed out after %0d cycles waiting for writebacks", runTimeout);
        end else begin
            // a few more cycles to catch stray strobes after the last one
            repeat (drainCycles) @(negedge clk);
            if (wbSeen != expectedTotal) begin
                failCount++;
                $display("saw %0d writebacks but the model retired %0d", wbSeen, expectedTotal);
            end
        end
        finishRun();
    end

endmodule

`default_nettype wire
